/* sim.f */
design/ulpi_pkg.sv
design/wb_map_pkg.sv
design/ulpi_reg_if.sv
design/ulpi_reset.sv
design/ulpi_reg_access.sv
design/ulpi_rx_monitor.sv
design/ulpi_control.sv
design/ulpi_top.sv
sim/ulpi_phy_model.sv
sim/tb_ulpi_top.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the ULPI testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ulpi_top -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_ulpi_top > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "Finished with errors" sim.log; then
  exit 1
fi
exit 0

/* sim/tb_ulpi_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ulpi_top;
  import ulpi_pkg::*;
  import wb_map_pkg::*;

  logic          sys_clock;
  logic          areset_n;
  logic          wb_cyc;
  logic          wb_stb;
  logic          wb_we;
  wb_addr_t      wb_adr;
  wb_data_t      wb_dat_w;
  wb_data_t      wb_dat_r;
  logic          wb_ack;
  logic          ulpi_dir;
  logic          ulpi_nxt;
  ulpi_data_t    ulpi_data_in;
  ulpi_data_t    ulpi_data_out;
  logic          ulpi_data_oe;
  logic          ulpi_stp;
  logic          ulpi_rst_n;
  logic [7:0]    inject_count;
  logic [7:0]    inject_served;
  logic [7:0]    abort_count;
  logic [7:0]    abort_served;
  int            model_errors;      // counted inside the PHY model
  ulpi_data_t    inject_byte;
  wb_data_t      shadow_regs [64];  // what the PHY should hold
  ulpi_data_t    shadow_rx;         // last injected RX CMD
  logic [1:0]    shadow_events;
  logic          shadow_ready;
  int            data_errors;
  int            rx_errors;
  int            bus_errors;
  int            timing_errors;

  ulpi_top dut0 (.*);

  ulpi_phy_model phy0 (.*);

  initial begin
    sys_clock = 1'b0;
    forever #50 sys_clock = ~sys_clock;
  end

  // expected Wishbone read data, from the shadows only
  function automatic wb_data_t expect_read(wb_addr_t adr);
    if (adr[7]) return shadow_regs[adr[5:0]];
    case (adr)
      8'h00:   return {shadow_ready, shadow_rx[6], 2'b00, shadow_rx[3:0]};
      8'h01:   return shadow_rx;
      8'h02:   return {6'b000000, shadow_events};
      default: return 8'h00;
    endcase
  endfunction

  task automatic print_summary();
    $display("errors: data %0d, rx %0d, bus %0d, timing %0d, model %0d",
             data_errors, rx_errors, bus_errors, timing_errors, model_errors);
  endtask

  task automatic fail_run(string why);
    $display("%s", why);
    print_summary();
    $display("Finished with errors");
    $finish;
  endtask

  task automatic check_data(string what, wb_data_t got, wb_data_t exp);
    if (got !== exp) begin
      data_errors++;
      $display("CHECK FAILED %0t: %s got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_rx(string what, ulpi_rx_byte_u got, ulpi_rx_byte_u exp);
    if (got !== exp) begin
      rx_errors++;
      $display("CHECK FAILED %0t: %s ls %b vbus %b ev %b id %b expected %02h", $time, what,
               got.cmd.linestate, got.cmd.vbus_state, got.cmd.rx_event, got.cmd.id, exp.raw);
    end
  endtask

  // one classic cycle, ack sampled mid-cycle
  task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
                           output wb_data_t rdata);
    int waited;
    @(posedge sys_clock);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    waited   = 0;
    do begin
      @(negedge sys_clock);
      waited++;
    end while (!wb_ack && waited < 2000);
    if (!wb_ack) begin
      fail_run("no Wishbone ack within 2000 cycles");
    end else begin
      rdata = wb_dat_r;
      @(posedge sys_clock);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
    end
  endtask

  task automatic phy_write(ulpi_addr_t a, wb_data_t d);
    wb_data_t unused;
    wb_access(1'b1, {2'b10, a}, d, unused);
    shadow_regs[a] = d;
  endtask

  task automatic read_and_check(wb_addr_t adr);
    wb_data_t got;
    wb_access(1'b0, adr, 8'h00, got);
    check_data($sformatf("read of %02h", adr), got, expect_read(adr));
  endtask

  task automatic inject_rx_cmd(ulpi_data_t b);
    int waited;
    @(posedge sys_clock);
    #1;
    inject_byte  = b;
    inject_count = inject_count + 8'd1;
    waited       = 0;
    while (inject_served != inject_count && waited < 200) begin
      @(negedge sys_clock);
      waited++;
    end
    if (inject_served != inject_count) begin
      fail_run("PHY model never sent the RX CMD");
    end else begin
      shadow_rx     = b;
      shadow_events = shadow_events | b[5:4];
    end
  endtask

  // PHY reset must stay low 16 cycles after areset_n
  initial begin : rst_watch
    int cycles;
    cycles = 0;
    while (areset_n !== 1'b1 && cycles < 100) begin
      @(negedge sys_clock);
      cycles++;
    end
    cycles = 0;
    while (ulpi_rst_n !== 1'b1 && cycles < 100) begin
      @(negedge sys_clock);
      cycles++;
    end
    if (ulpi_rst_n !== 1'b1 || cycles < 16) begin
      timing_errors++;
      $display("PHY reset released after %0d cycles, expected at least 16", cycles);
    end
  end

  // the link must never drive against the PHY
  always @(negedge sys_clock) begin
    if (ulpi_data_oe && ulpi_dir) begin
      bus_errors++;
      $display("bus contention at %0t: link drives while dir is high", $time);
    end
  end

  initial begin
    ulpi_addr_t    addr_list [8];
    ulpi_addr_t    a;
    wb_data_t      d;
    wb_data_t      got;
    ulpi_rx_byte_u rx_got;
    ulpi_rx_byte_u rx_exp;
    int            waited;
    void'($urandom(65291));
    areset_n      = 1'b0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    inject_count  = '0;
    inject_byte   = '0;
    abort_count   = '0;
    shadow_rx     = '0;
    shadow_events = '0;
    shadow_ready  = 1'b0;
    data_errors   = 0;
    rx_errors     = 0;
    bus_errors    = 0;
    timing_errors = 0;
    waited        = 0;
    repeat (8) @(posedge sys_clock);
    #1 areset_n = 1'b1;

    // PHY out of reset, model still holds dir for at least 5 cycles
    while (ulpi_rst_n !== 1'b1 && waited < 100) begin
      @(negedge sys_clock);
      waited++;
    end
    read_and_check(wb_status_addr);  // not ready yet
    a = 6'($urandom);
    phy_write(a, 8'($urandom));      // waits out the reset sequence
    shadow_ready = 1'b1;
    read_and_check({2'b10, a});
    read_and_check(wb_status_addr);

    for (int i = 0; i < 8; i++) begin
      addr_list[i] = 6'($urandom);
      phy_write(addr_list[i], 8'($urandom));
    end
    for (int i = 0; i < 8; i++) read_and_check({2'b10, addr_list[i]});

    inject_rx_cmd(8'($urandom) | 8'h30);  // both event flags set
    read_and_check(wb_status_addr);
    wb_access(1'b0, wb_rxcmd_addr, 8'h00, got);
    rx_got.raw = got;
    rx_exp.raw = expect_read(wb_rxcmd_addr);
    check_rx("rxcmd register", rx_got, rx_exp);
    read_and_check(wb_event_addr);
    wb_access(1'b1, wb_event_addr, 8'h01, got);
    shadow_events = shadow_events & 2'b10;
    read_and_check(wb_event_addr);
    wb_access(1'b1, wb_event_addr, 8'h03, got);
    shadow_events = 2'b00;
    read_and_check(wb_event_addr);

    // aborted write, then aborted read
    @(posedge sys_clock);
    #1 abort_count = abort_count + 8'd1;
    a = 6'($urandom);
    d = 8'($urandom);
    phy_write(a, d);
    @(posedge sys_clock);
    #1 abort_count = abort_count + 8'd1;
    read_and_check({2'b10, a});
    if (abort_served != abort_count) begin
      bus_errors++;
      $display("PHY model did not abort every requested command");
    end

    print_summary();
    if (data_errors + rx_errors + bus_errors + timing_errors + model_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/ulpi_phy_model.sv */
`timescale 1ns/100ps
`default_nettype none

// behavioral ULPI PHY, register file plus RX CMD and abort on request
module ulpi_phy_model (
  input  logic                 sys_clock,
  input  logic                 ulpi_rst_n,
  input  ulpi_pkg::ulpi_data_t ulpi_data_out,
  input  logic                 ulpi_data_oe,
  input  logic                 ulpi_stp,
  output logic                 ulpi_dir,
  output logic                 ulpi_nxt,
  output ulpi_pkg::ulpi_data_t ulpi_data_in,
  input  logic [7:0]           inject_count,   // bumped by the testbench per RX CMD
  input  ulpi_pkg::ulpi_data_t inject_byte,
  output logic [7:0]           inject_served,
  input  logic [7:0]           abort_count,    // bumped per abort request
  output logic [7:0]           abort_served,
  output int                   model_errors    // protocol faults seen on the bus
);
  import ulpi_pkg::*;

  ulpi_data_t regs [64];
  ulpi_data_t cmd;
  ulpi_data_t wdata;
  int         waited;

  // outputs change 1 ns after the edge, DUT state already settled
  task automatic next_cycle();
    @(posedge sys_clock);
    #1;
  endtask

  // nxt after 0 to 3 idle cycles, held for one cycle
  task automatic accept_byte();
    repeat ($urandom_range(3, 0)) next_cycle();
    ulpi_nxt = 1'b1;
  endtask

  initial begin
    for (int i = 0; i < 64; i++) begin
      regs[i] = 8'(i * 37 + 11);  // fill tied to the whole address
    end
    ulpi_dir      = 1'b1;  // PHY owns the bus while in reset
    ulpi_nxt      = 1'b0;
    ulpi_data_in  = '0;
    inject_served = '0;
    abort_served  = '0;
    model_errors  = 0;
    waited        = 0;
    while (ulpi_rst_n !== 1'b1 && waited < 1000) begin
      next_cycle();
      waited++;
    end
    if (ulpi_rst_n !== 1'b1) begin
      model_errors++;
      $display("PHY model: reset never released");
    end
    repeat ($urandom_range(20, 5)) next_cycle();  // clock startup
    ulpi_dir = 1'b0;
    forever begin
      next_cycle();
      if (inject_served != inject_count && !ulpi_data_oe) begin
        ulpi_dir = 1'b1;  // turnaround cycle
        next_cycle();
        ulpi_data_in = inject_byte;
        next_cycle();
        ulpi_dir      = 1'b0;
        ulpi_data_in  = '0;
        inject_served = inject_served + 8'd1;
      end else if (ulpi_data_oe && ulpi_data_out[7]) begin
        cmd = ulpi_data_out;
        if (abort_served != abort_count) begin
          ulpi_dir = 1'b1;  // single cycle, never an RX CMD
          next_cycle();
          ulpi_dir     = 1'b0;
          abort_served = abort_served + 8'd1;
        end else begin
          accept_byte();
          next_cycle();
          ulpi_nxt = 1'b0;
          if (cmd[7:6] == tx_cmd_reg_read) begin
            ulpi_dir = 1'b1;  // turnaround
            next_cycle();
            ulpi_data_in = regs[cmd[5:0]];
            next_cycle();
            ulpi_dir     = 1'b0;
            ulpi_data_in = '0;
          end else begin
            accept_byte();
            wdata = ulpi_data_out;  // write data on the bus now
            next_cycle();
            ulpi_nxt = 1'b0;
            // stp cycle with the bus at zero
            if (ulpi_stp !== 1'b1 || ulpi_data_out !== 8'h00) begin
              model_errors++;
              $display("PHY model: no stp with the bus at zero after register write data");
            end
            regs[cmd[5:0]] = wdata;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/ulpi_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ulpi_top (
  input  logic                 sys_clock,
  input  logic                 areset_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  wb_map_pkg::wb_addr_t wb_adr,
  input  wb_map_pkg::wb_data_t wb_dat_w,
  output wb_map_pkg::wb_data_t wb_dat_r,
  output logic                 wb_ack,
  input  logic                 ulpi_dir,
  input  logic                 ulpi_nxt,
  input  ulpi_pkg::ulpi_data_t ulpi_data_in,
  output ulpi_pkg::ulpi_data_t ulpi_data_out,
  output logic                 ulpi_data_oe,
  output logic                 ulpi_stp,
  output logic                 ulpi_rst_n
);
  import ulpi_pkg::*;

  logic          usb_reset;
  logic          read_pending;  // engine to monitor
  logic [1:0]    event_clear;
  logic [1:0]    linestate;
  logic [1:0]    vbus_state;
  logic          id;
  logic [1:0]    events;
  ulpi_rx_byte_u rx_last;

  ulpi_reg_if reg_bus ();

  ulpi_reset u_reset (
    .sys_clock  (sys_clock),
    .areset_n   (areset_n),
    .ulpi_dir   (ulpi_dir),
    .ulpi_rst_n (ulpi_rst_n),
    .usb_reset  (usb_reset)
  );

  ulpi_reg_access u_engine (
    .sys_clock     (sys_clock),
    .areset_n      (areset_n),
    .usb_reset     (usb_reset),
    .reg_bus       (reg_bus.eng),
    .ulpi_dir      (ulpi_dir),
    .ulpi_nxt      (ulpi_nxt),
    .ulpi_data_in  (ulpi_data_in),
    .ulpi_data_out (ulpi_data_out),
    .ulpi_data_oe  (ulpi_data_oe),
    .ulpi_stp      (ulpi_stp),
    .read_pending  (read_pending)
  );

  ulpi_rx_monitor u_monitor (
    .sys_clock    (sys_clock),
    .areset_n     (areset_n),
    .usb_reset    (usb_reset),
    .ulpi_dir     (ulpi_dir),
    .ulpi_nxt     (ulpi_nxt),
    .ulpi_data_in (ulpi_data_in),
    .read_pending (read_pending),
    .event_clear  (event_clear),
    .rx_last      (rx_last),
    .linestate    (linestate),
    .vbus_state   (vbus_state),
    .id           (id),
    .events       (events)
  );

  ulpi_control u_control (
    .sys_clock   (sys_clock),
    .areset_n    (areset_n),
    .usb_reset   (usb_reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .reg_bus     (reg_bus.ctrl),
    .rx_last     (rx_last),
    .linestate   (linestate),
    .vbus_state  (vbus_state),
    .id          (id),
    .events      (events),
    .event_clear (event_clear)
  );

endmodule

`default_nettype wire

/* design/ulpi_control.sv */
`timescale 1ns/100ps
`default_nettype none

module ulpi_control (
  input  logic                    sys_clock,
  input  logic                    areset_n,
  input  logic                    usb_reset,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  wb_map_pkg::wb_addr_t    wb_adr,
  input  wb_map_pkg::wb_data_t    wb_dat_w,
  output wb_map_pkg::wb_data_t    wb_dat_r,
  output logic                    wb_ack,
  ulpi_reg_if.ctrl                reg_bus,
  input  ulpi_pkg::ulpi_rx_byte_u rx_last,
  input  logic [1:0]              linestate,
  input  logic [1:0]              vbus_state,
  input  logic                    id,
  input  logic [1:0]              events,
  output logic [1:0]              event_clear
);
  import ulpi_pkg::*;
  import wb_map_pkg::*;

  logic       wb_start;     // new cycle, not acked yet
  logic       phy_sel;      // PHY register window
  logic       phy_busy;     // PHY access in flight
  ulpi_addr_t phy_addr;
  wb_data_t   status_word;
  wb_data_t   local_dat;

  assign wb_start = wb_cyc && wb_stb && !wb_ack && !phy_busy;
  assign phy_sel  = wb_adr[wb_phy_window_bit];
  assign phy_addr = wb_adr[$bits(ulpi_addr_t)-1:0];

  // master holds adr and data until ack, so these stay stable under req
  assign reg_bus.write = wb_we;
  assign reg_bus.addr  = phy_addr;
  assign reg_bus.wdata = wb_dat_w;

  // ready in bit 7, rest in RX CMD positions
  assign status_word = {!usb_reset, id, 2'b00, vbus_state, linestate};

  always_comb begin
    case (wb_adr)
      wb_status_addr: local_dat = status_word;
      wb_rxcmd_addr:  local_dat = rx_last.raw;
      wb_event_addr:  local_dat = {6'b000000, events};
      default:        local_dat = '0;  // unmapped reads as zero
    endcase
  end

  // write 1 clears, ro registers just ack
  assign event_clear = (wb_start && !phy_sel && wb_we && wb_adr == wb_event_addr) ?
                       wb_dat_w[1:0] : 2'b00;

  always_ff @(posedge sys_clock or negedge areset_n) begin
    if (!areset_n) begin
      wb_ack      <= 1'b0;
      phy_busy    <= 1'b0;
      reg_bus.req <= 1'b0;
    end else begin
      wb_ack <= 1'b0;  // single cycle pulse
      if (wb_start && !phy_sel) begin
        wb_ack <= 1'b1;  // local, next cycle
      end else if (wb_start) begin
        phy_busy    <= 1'b1;
        reg_bus.req <= !usb_reset;  // waits out the reset sequence
      end
      if (phy_busy) begin
        if (reg_bus.done) begin
          reg_bus.req <= 1'b0;
          phy_busy    <= 1'b0;
          wb_ack      <= 1'b1;
        end else if (!usb_reset) begin
          reg_bus.req <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge sys_clock) begin
    if (wb_start && !phy_sel) begin
      wb_dat_r <= local_dat;
    end else if (phy_busy && reg_bus.done) begin
      wb_dat_r <= reg_bus.rdata;  // stale on writes, master ignores it
    end
  end

  a_ack_pulse: assert property (
    @(posedge sys_clock) disable iff (!areset_n)
    wb_ack |=> !wb_ack
  ) else $error("wb_ack held for two cycles");

endmodule

`default_nettype wire

/* design/ulpi_rx_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module ulpi_rx_monitor (
  input  logic                    sys_clock,
  input  logic                    areset_n,
  input  logic                    usb_reset,
  input  logic                    ulpi_dir,
  input  logic                    ulpi_nxt,
  input  ulpi_pkg::ulpi_data_t    ulpi_data_in,
  input  logic                    read_pending,
  input  logic [1:0]              event_clear,  // write-1-to-clear mask
  output ulpi_pkg::ulpi_rx_byte_u rx_last,
  output logic [1:0]              linestate,
  output logic [1:0]              vbus_state,
  output logic                    id,
  output logic [1:0]              events
);
  import ulpi_pkg::*;

  logic          dir_q;         // first dir-high cycle is turnaround
  logic          rx_cmd_valid;
  ulpi_rx_byte_u rx_byte;

  assign rx_byte.raw = ulpi_data_in;

  // nxt high would mean packet data, read_pending means register data
  assign rx_cmd_valid = ulpi_dir && dir_q && !ulpi_nxt && !read_pending;

  always_ff @(posedge sys_clock or negedge areset_n) begin
    if (!areset_n) begin
      dir_q   <= 1'b0;
      rx_last <= '0;
      events  <= '0;
    end else if (usb_reset) begin
      dir_q   <= 1'b0;
      rx_last <= '0;
      events  <= '0;
    end else begin
      dir_q <= ulpi_dir;
      if (rx_cmd_valid) begin
        rx_last <= rx_byte;
      end
      // a new event wins over a clear in the same cycle
      events <= (events & ~event_clear) | (rx_cmd_valid ? rx_byte.cmd.rx_event : 2'b00);
    end
  end

  assign linestate  = rx_last.cmd.linestate;
  assign vbus_state = rx_last.cmd.vbus_state;
  assign id         = rx_last.cmd.id;

endmodule

`default_nettype wire

/* design/ulpi_reg_access.sv */
`timescale 1ns/100ps
`default_nettype none

module ulpi_reg_access (
  input  logic                 sys_clock,
  input  logic                 areset_n,
  input  logic                 usb_reset,
  ulpi_reg_if.eng              reg_bus,
  input  logic                 ulpi_dir,
  input  logic                 ulpi_nxt,
  input  ulpi_pkg::ulpi_data_t ulpi_data_in,
  output ulpi_pkg::ulpi_data_t ulpi_data_out,
  output logic                 ulpi_data_oe,
  output logic                 ulpi_stp,
  output logic                 read_pending  // read turnaround, to the monitor
);
  import ulpi_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_cmd,    // TX CMD on the bus until nxt
    st_wdata,  // write data until nxt
    st_stop,   // stp, bus at zero
    st_turn,   // read, waiting for dir
    st_rdata   // read data on the bus
  } state_t;

  state_t     state;
  state_t     state_next;
  ulpi_data_t tx_cmd;
  logic       link_drive;

  assign tx_cmd = {(reg_bus.write ? tx_cmd_reg_write : tx_cmd_reg_read), reg_bus.addr};

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        // done still high here means req is about to drop
        if (reg_bus.req && !reg_bus.done && !ulpi_dir) state_next = st_cmd;
      end
      st_cmd: begin
        if (ulpi_dir) state_next = st_idle;  // aborted, retry when dir falls
        else if (ulpi_nxt) state_next = reg_bus.write ? st_wdata : st_turn;
      end
      st_wdata: begin
        if (ulpi_dir) state_next = st_idle;
        else if (ulpi_nxt) state_next = st_stop;
      end
      st_stop: state_next = st_idle;
      st_turn: begin
        if (ulpi_dir) state_next = st_rdata;  // turnaround cycle
      end
      st_rdata: state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge sys_clock or negedge areset_n) begin
    if (!areset_n) begin
      state        <= st_idle;
      reg_bus.done <= 1'b0;
    end else if (usb_reset) begin
      state        <= st_idle;
      reg_bus.done <= 1'b0;
    end else begin
      state        <= state_next;
      reg_bus.done <= (state == st_stop) || (state == st_rdata);  // cycle after
    end
  end

  // read byte, one cycle after dir rose
  always_ff @(posedge sys_clock) begin
    if (state == st_rdata) begin
      reg_bus.rdata <= ulpi_data_in;
    end
  end

  // never drive against the PHY
  assign link_drive   = (state == st_cmd || state == st_wdata || state == st_stop) && !ulpi_dir;
  assign ulpi_data_oe = link_drive;
  assign ulpi_stp     = (state == st_stop) && !ulpi_dir;
  assign read_pending = (state == st_turn) || (state == st_rdata);

  always_comb begin
    ulpi_data_out = '0;  // idle and stp cycles
    if (link_drive) begin
      case (state)
        st_cmd:   ulpi_data_out = tx_cmd;
        st_wdata: ulpi_data_out = reg_bus.wdata;
        default:  ulpi_data_out = '0;
      endcase
    end
  end

  // off the bus while dir is high and in the turnaround after it falls
  a_no_contention: assert property (
    @(posedge sys_clock) disable iff (!areset_n)
    !(ulpi_data_oe && (ulpi_dir || $past(ulpi_dir)))
  ) else $error("link drives the ULPI bus while the PHY owns it or in turnaround");

  // done only ends a request the control side still holds
  a_done_in_req: assert property (
    @(posedge sys_clock) disable iff (!areset_n)
    reg_bus.done |-> reg_bus.req
  ) else $error("done without req");

endmodule

`default_nettype wire

/* design/ulpi_reset.sv */
`timescale 1ns/100ps
`default_nettype none

module ulpi_reset (
  input  logic sys_clock,
  input  logic areset_n,
  input  logic ulpi_dir,
  output logic ulpi_rst_n,  // to PHY, active low
  output logic usb_reset    // internal, active high
);
  import ulpi_pkg::*;

  logic [rst_count_bits-1:0]   reset_count;
  logic [rst_delay_stages-1:0] reset_delay;
  logic                        bus_free;     // sticky, PHY let go of dir once
  logic                        bus_free_now;

  assign ulpi_rst_n = reset_count[rst_count_bits-1];
  assign usb_reset  = reset_delay[rst_delay_stages-1];

  // PHY holds dir high until its clock is up
  assign bus_free_now = ulpi_rst_n && !ulpi_dir;

  // saturates once the top bit sets
  always_ff @(posedge sys_clock or negedge areset_n) begin
    if (!areset_n) begin
      reset_count <= '0;
    end else if (!reset_count[rst_count_bits-1]) begin
      reset_count <= reset_count + rst_count_bits'(1);
    end
  end

  // later dir activity (RX CMDs) must not re-enter reset
  always_ff @(posedge sys_clock or negedge areset_n) begin
    if (!areset_n) begin
      bus_free <= 1'b0;
    end else if (bus_free_now) begin
      bus_free <= 1'b1;
    end
  end

  always_ff @(posedge sys_clock or negedge areset_n) begin
    if (!areset_n) begin
      reset_delay <= '1;
    end else begin
      reset_delay <= {reset_delay[rst_delay_stages-2:0], !(bus_free || bus_free_now)};
    end
  end

  // internal logic stays in reset as long as the PHY does
  a_reset_order: assert property (
    @(posedge sys_clock) disable iff (!areset_n)
    !ulpi_rst_n |-> usb_reset
  ) else $error("usb_reset released while PHY still in reset");

endmodule

`default_nettype wire

/* design/ulpi_reg_if.sv */
`timescale 1ns/100ps
`default_nettype none

// register access request, control side to bus engine
interface ulpi_reg_if;
  import ulpi_pkg::*;

  logic       req;    // held until done
  logic       write;  // 1 = register write, 0 = read
  ulpi_addr_t addr;
  ulpi_data_t wdata;
  ulpi_data_t rdata;  // valid with done
  logic       done;   // one cycle

  modport ctrl (
    output req,
    output write,
    output addr,
    output wdata,
    input  rdata,
    input  done
  );

  modport eng (
    input  req,
    input  write,
    input  addr,
    input  wdata,
    output rdata,
    output done
  );

endinterface

`default_nettype wire

/* design/wb_map_pkg.sv */
`default_nettype none

package wb_map_pkg;

  localparam int wb_addr_bits = 8;
  localparam int wb_data_bits = 8;

  typedef logic [wb_addr_bits-1:0] wb_addr_t;
  typedef logic [wb_data_bits-1:0] wb_data_t;

  // address bit 7 set selects PHY register adr[5:0]
  localparam int wb_phy_window_bit = 7;

  // local registers, bit 7 clear
  localparam wb_addr_t wb_status_addr = 8'h00;  // ro: ready, id, vbus, linestate
  localparam wb_addr_t wb_rxcmd_addr  = 8'h01;  // ro: last raw RX CMD
  localparam wb_addr_t wb_event_addr  = 8'h02;  // sticky rx_event, write 1 clears

endpackage

`default_nettype wire

/* design/ulpi_pkg.sv */
`default_nettype none

package ulpi_pkg;

  // ULPI bus byte, both directions
  typedef logic [7:0] ulpi_data_t;

  // immediate register address, the low six bits of a TX CMD
  typedef logic [5:0] ulpi_addr_t;

  // RX CMD layout as the PHY sends it while dir is high
  typedef struct packed {
    logic       alt_int;     // bit 7
    logic       id;          // bit 6, id pin state
    logic [1:0] rx_event;    // 5:4
    logic [1:0] vbus_state;  // 3:2
    logic [1:0] linestate;   // 1:0, dp/dm
  } ulpi_rx_cmd_t;

  // one byte from the PHY, read data or RX CMD depending on bus phase
  typedef union packed {
    ulpi_data_t   raw;  // register read data
    ulpi_rx_cmd_t cmd;  // status byte
  } ulpi_rx_byte_u;

  // TX CMD prefixes, sit above the 6-bit address
  localparam logic [1:0] tx_cmd_reg_write = 2'b10;
  localparam logic [1:0] tx_cmd_reg_read  = 2'b11;

  // PHY reset released when the top counter bit sets (16 cycles)
  localparam int rst_count_bits = 5;

  // internal reset release delay, in sys_clock cycles
  localparam int rst_delay_stages = 3;

endpackage

`default_nettype wire
